// File: verilog/rv32i_pkg.sv
`default_nettype none

package rv32i_pkg;

    typedef logic [31:0] rv32i_word;

    // base opcodes of the 32-bit encoding
    typedef enum logic [6:0]
    {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_csr   = 7'b1110011
    } rv32i_opcode;

    // ------------------------------------------------------------------------
    // instruction formats seen by the predecoder
    // ------------------------------------------------------------------------

    typedef struct packed
    {
        logic        imm20;
        logic [9:0]  imm10_1;
        logic        imm11;
        logic [7:0]  imm19_12;
        logic [4:0]  rd;
        rv32i_opcode opcode;
    } j_fmt_t;

    typedef struct packed
    {
        logic        imm12;
        logic [5:0]  imm10_5;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [3:0]  imm4_1;
        logic        imm11;
        rv32i_opcode opcode;
    } b_fmt_t;

    // one fetched word read as either the jump or the branch layout
    typedef union packed
    {
        j_fmt_t j;
        b_fmt_t b;
    } rv32i_inst_u;

endpackage

`default_nettype wire

// File: verilog/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // ------------------------------------------------------------------------
    // sizes and start address
    // ------------------------------------------------------------------------

    localparam rv32i_pkg::rv32i_word RESET_PC = 32'h0000_0060;

    localparam int IMEM_WORDS = 32;
    localparam int IMEM_AW = 5; // log2 of IMEM_WORDS
    localparam int IMEM_WAIT = 2; // stalled access cycles before pready
    localparam int IMEM_WAIT_W = $clog2(IMEM_WAIT + 1);

    typedef logic [IMEM_WAIT_W-1:0] wait_cnt_t;

    // ------------------------------------------------------------------------
    // stage interfaces
    // ------------------------------------------------------------------------

    // handed to the instruction queue
    typedef struct packed
    {
        rv32i_pkg::rv32i_word pc;
        rv32i_pkg::rv32i_word inst;
        rv32i_pkg::rv32i_word pc_next;
        logic                 br_pred;
    } fetch_bundle_t;

    // corrected pc from the back end
    typedef struct packed
    {
        logic                 valid;
        rv32i_pkg::rv32i_word pc;
    } redirect_t;

    typedef struct packed
    {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [31:0] paddr;
    } apb_req_t;

    typedef struct packed
    {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

endpackage

`default_nettype wire

// File: verilog/inst_predecode.sv
`timescale 1ns/1ns
`default_nettype none

module inst_predecode
(
    input  wire rv32i_pkg::rv32i_word pc_i,
    input  wire rv32i_pkg::rv32i_word inst_i,
    output rv32i_pkg::rv32i_word      pc_next_o,
    output logic                      br_pred_o
);

    rv32i_pkg::rv32i_inst_u inst_u;
    rv32i_pkg::rv32i_word   j_imm;
    rv32i_pkg::rv32i_word   b_imm;
    logic is_jal;
    logic is_br;

    assign inst_u = inst_i;

    // ------------------------------------------------------------------------
    // sign extended immediates with bit 0 forced low
    // ------------------------------------------------------------------------

    assign j_imm = {{12{inst_u.j.imm20}}, inst_u.j.imm19_12, inst_u.j.imm11,
                    inst_u.j.imm10_1, 1'b0};
    assign b_imm = {{20{inst_u.b.imm12}}, inst_u.b.imm11, inst_u.b.imm10_5,
                    inst_u.b.imm4_1, 1'b0};

    assign is_jal = (inst_u.j.opcode == rv32i_pkg::op_jal);
    assign is_br  = (inst_u.b.opcode == rv32i_pkg::op_br);

    // backward branches are assumed to be loops and predicted taken
    always_comb
    begin
        if (is_jal)
        begin
            pc_next_o = pc_i + j_imm;
            br_pred_o = 1'b1;
        end
        else if (is_br && b_imm[31])
        begin
            pc_next_o = pc_i + b_imm;
            br_pred_o = 1'b1;
        end
        else
        begin
            pc_next_o = pc_i + 32'd4; // jalr target is unknown here
            br_pred_o = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: verilog/fetch_pc.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_pc
(
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 advance_i,
    input  wire rv32i_pkg::rv32i_word pc_next_i,
    input  wire fetch_pkg::redirect_t redirect_i,
    output rv32i_pkg::rv32i_word      pc_o
);

    // ------------------------------------------------------------------------
    // pc register
    // ------------------------------------------------------------------------

    // the back end correction wins over our own prediction
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc_o <= fetch_pkg::RESET_PC;
        end
        else if (redirect_i.valid)
        begin
            pc_o <= redirect_i.pc;
        end
        else if (advance_i)
        begin
            pc_o <= pc_next_i; // predicted target of the bundle just accepted
        end
    end

endmodule

`default_nettype wire

// File: verilog/imem_apb.sv
`timescale 1ns/1ns
`default_nettype none

module imem_apb
(
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire fetch_pkg::apb_req_t apb_req_i,
    output fetch_pkg::apb_rsp_t      apb_rsp_o
);

    rv32i_pkg::rv32i_word rom [fetch_pkg::IMEM_WORDS];

    logic [fetch_pkg::IMEM_AW-1:0] idx;
    fetch_pkg::wait_cnt_t wait_cnt;
    logic access;
    logic ready;

    initial
    begin
        $readmemh("imem.hex", rom);
    end

    assign idx = apb_req_i.paddr[fetch_pkg::IMEM_AW+1:2]; // upper bits wrap

    // ------------------------------------------------------------------------
    // wait states counted from the first penable cycle
    // ------------------------------------------------------------------------

    assign access = apb_req_i.psel && apb_req_i.penable && !apb_req_i.pwrite;
    assign ready  = access && (wait_cnt == fetch_pkg::wait_cnt_t'(fetch_pkg::IMEM_WAIT));

    always_ff @(posedge clk)
    begin
        if (rst)
            wait_cnt <= '0;
        else if (access && !ready)
            wait_cnt <= wait_cnt + 1'b1;
        else
            wait_cnt <= '0;
    end

    always_comb
    begin
        apb_rsp_o.pready  = ready;
        apb_rsp_o.prdata  = ready ? rom[idx] : '0;
        apb_rsp_o.pslverr = 1'b0; // every address maps somewhere
    end

endmodule

`default_nettype wire

// File: verilog/fetch_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_ctrl
(
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire rv32i_pkg::rv32i_word     pc_i,
    input  wire rv32i_pkg::rv32i_word     pc_next_i,
    input  wire logic                     br_pred_i,
    input  wire fetch_pkg::apb_rsp_t      apb_rsp_i,
    input  wire fetch_pkg::redirect_t     redirect_i,
    input  wire logic                     bundle_ready_i,
    output fetch_pkg::apb_req_t           apb_req_o,
    output logic                          advance_o,
    output fetch_pkg::fetch_bundle_t      bundle_o,
    output logic                          bundle_valid_o
);

    typedef enum logic [1:0]
    {
        IDLE,
        SETUP,
        ACCESS,
        OUT
    } state_t;

    state_t state, state_nx;
    logic discard; // a redirect hit this transfer, so its word is dropped
    rv32i_pkg::rv32i_word addr_q; // held for the whole transfer even if pc moves

    always_comb
    begin
        state_nx = state;
        case (state)
            IDLE:   state_nx = SETUP;
            SETUP:  state_nx = ACCESS;
            ACCESS:
            begin
                if (apb_rsp_i.pready)
                    state_nx = (discard || redirect_i.valid) ? IDLE : OUT;
            end
            OUT:
            begin
                if (redirect_i.valid || bundle_ready_i)
                    state_nx = IDLE;
            end
            default: state_nx = IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state   <= IDLE;
            discard <= 1'b0;
        end
        else
        begin
            state <= state_nx;
            if (state == IDLE)
                discard <= 1'b0;
            else if (redirect_i.valid && (state == SETUP || state == ACCESS))
                discard <= 1'b1;
        end
    end

    // transfer address and the captured fetch bundle
    always_ff @(posedge clk)
    begin
        if (state == IDLE)
            addr_q <= redirect_i.valid ? redirect_i.pc : pc_i; // pc loads this same edge
        if (state == ACCESS && apb_rsp_i.pready)
        begin
            bundle_o.pc      <= addr_q;
            bundle_o.inst    <= apb_rsp_i.prdata;
            bundle_o.pc_next <= pc_next_i;
            bundle_o.br_pred <= br_pred_i;
        end
    end

    always_comb
    begin
        apb_req_o.psel    = (state == SETUP) || (state == ACCESS);
        apb_req_o.penable = (state == ACCESS);
        apb_req_o.pwrite  = 1'b0; // read only port
        apb_req_o.paddr   = addr_q;
    end

    assign bundle_valid_o = (state == OUT) && !redirect_i.valid;
    assign advance_o      = bundle_valid_o && bundle_ready_i;

endmodule

`default_nettype wire

// File: verilog/fetch_top.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_top
(
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire fetch_pkg::redirect_t redirect_i,
    input  wire logic                 bundle_ready_i,
    output fetch_pkg::fetch_bundle_t  bundle_o,
    output logic                      bundle_valid_o
);

    rv32i_pkg::rv32i_word pc;
    rv32i_pkg::rv32i_word pred_pc_next;
    logic                 pred_br;
    logic                 advance;
    fetch_pkg::apb_req_t  apb_req;
    fetch_pkg::apb_rsp_t  apb_rsp;

    fetch_ctrl ctrl_inst
    (
        .clk            (clk),
        .rst            (rst),
        .pc_i           (pc),
        .pc_next_i      (pred_pc_next),
        .br_pred_i      (pred_br),
        .apb_rsp_i      (apb_rsp),
        .redirect_i     (redirect_i),
        .bundle_ready_i (bundle_ready_i),
        .apb_req_o      (apb_req),
        .advance_o      (advance),
        .bundle_o       (bundle_o),
        .bundle_valid_o (bundle_valid_o)
    );

    // advances to the pc_next captured in the bundle
    fetch_pc pc_inst
    (
        .clk        (clk),
        .rst        (rst),
        .advance_i  (advance),
        .pc_next_i  (bundle_o.pc_next),
        .redirect_i (redirect_i),
        .pc_o       (pc)
    );

    inst_predecode predecode_inst
    (
        .pc_i      (pc),
        .inst_i    (apb_rsp.prdata),
        .pc_next_o (pred_pc_next),
        .br_pred_o (pred_br)
    );

    imem_apb imem_inst
    (
        .clk       (clk),
        .rst       (rst),
        .apb_req_i (apb_req),
        .apb_rsp_o (apb_rsp)
    );

endmodule

`default_nettype wire

// File: tb/fetch_sva.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_sva
(
    input wire logic                     clk,
    input wire logic                     rst,
    input wire fetch_pkg::apb_req_t      apb_req_i,
    input wire fetch_pkg::fetch_bundle_t bundle_i,
    input wire logic                     bundle_valid_i,
    input wire logic                     bundle_ready_i
);

    int fail_count = 0; // number of assertion failures so far

    // ------------------------------------------------------------------------
    // APB read protocol
    // ------------------------------------------------------------------------

    a_setup_first: assert property (@(posedge clk) disable iff (rst)
        $rose(apb_req_i.penable) |-> $past(apb_req_i.psel && !apb_req_i.penable))
        else
        begin
            fail_count++;
            $error("penable rose without a preceding setup cycle");
        end

    // a transfer never starts in the cycle right after another one
    a_paddr_stable: assert property (@(posedge clk) disable iff (rst)
        apb_req_i.psel && $past(apb_req_i.psel) |-> $stable(apb_req_i.paddr))
        else
        begin
            fail_count++;
            $error("paddr changed in the middle of a transfer");
        end

    a_no_write: assert property (@(posedge clk) disable iff (rst)
        !apb_req_i.pwrite)
        else
        begin
            fail_count++;
            $error("pwrite went high on the instruction port");
        end

    // ------------------------------------------------------------------------
    // instruction queue handshake
    // ------------------------------------------------------------------------

    a_bundle_held: assert property (@(posedge clk) disable iff (rst)
        bundle_valid_i && !bundle_ready_i |=> $stable(bundle_i))
        else
        begin
            fail_count++;
            $error("bundle changed while waiting for ready");
        end

endmodule

bind fetch_ctrl fetch_sva fetch_sva_inst
(
    .clk            (clk),
    .rst            (rst),
    .apb_req_i      (apb_req_o),
    .bundle_i       (bundle_o),
    .bundle_valid_i (bundle_valid_o),
    .bundle_ready_i (bundle_ready_i)
);

`default_nettype wire

// File: tb/fetch_tb.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_tb;

    typedef enum logic [1:0]
    {
        ACT_NONE,
        ACT_IDLE,
        ACT_XFER
    } action_t;

    // a row redirects first if asked, then takes count bundles
    typedef struct packed
    {
        action_t              action;
        logic [1:0]           skew; // cycles past the setup cycle before the redirect
        rv32i_pkg::rv32i_word target;
        logic [5:0]           count;
        logic                 rand_delay;
        logic [3:0]           delay; // cycles with ready held low
    } step_t;

    localparam int NUM_STEPS = 9;
    localparam int TIMEOUT = 40;

    localparam step_t STEPS [NUM_STEPS] = '{
        '{ACT_NONE, 2'd0, 32'h0000_0000, 6'd21, 1'b0, 4'd0}, // one lap of the loop
        '{ACT_NONE, 2'd0, 32'h0000_0000, 6'd12, 1'b1, 4'd0},
        '{ACT_XFER, 2'd0, 32'h0000_0028, 6'd6, 1'b0, 4'd1}, // hits the setup cycle
        '{ACT_IDLE, 2'd0, 32'h0000_0078, 6'd5, 1'b0, 4'd0}, // runs past the ROM top
        '{ACT_XFER, 2'd1, 32'h0000_0054, 6'd6, 1'b1, 4'd0},
        '{ACT_XFER, 2'd3, 32'h0000_0100, 6'd4, 1'b0, 4'd2}, // lands on the pready cycle
        '{ACT_IDLE, 2'd0, 32'h0000_0048, 6'd5, 1'b1, 4'd0},
        '{ACT_XFER, 2'd2, 32'h0000_0060, 6'd21, 1'b1, 4'd0},
        '{ACT_IDLE, 2'd0, 32'h0000_005c, 6'd3, 1'b0, 4'd3}
    };

    logic                     clk;
    logic                     rst;
    fetch_pkg::redirect_t     redirect;
    logic                     bundle_ready;
    fetch_pkg::fetch_bundle_t bundle;
    logic                     bundle_valid;

    rv32i_pkg::rv32i_word mem [fetch_pkg::IMEM_WORDS];
    rv32i_pkg::rv32i_word model_pc;
    logic [31:0]          rng;
    int                   bundle_errs;
    int                   pc_errs;
    int                   valid_errs;
    logic                 timed_out;

    fetch_top fetch_top_inst
    (
        .clk            (clk),
        .rst            (rst),
        .redirect_i     (redirect),
        .bundle_ready_i (bundle_ready),
        .bundle_o       (bundle),
        .bundle_valid_o (bundle_valid)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // ------------------------------------------------------------------------
    // reference model of the static predictor
    // ------------------------------------------------------------------------

    function automatic fetch_pkg::fetch_bundle_t expect_bundle(input rv32i_pkg::rv32i_word pc);
        fetch_pkg::fetch_bundle_t b;
        rv32i_pkg::rv32i_word     w;
        rv32i_pkg::rv32i_word     j_off;
        rv32i_pkg::rv32i_word     b_off;
        w = mem[(pc >> 2) % fetch_pkg::IMEM_WORDS];
        j_off = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        b_off = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        b.pc = pc;
        b.inst = w;
        b.br_pred = 1'b1;
        if (w[6:0] == 7'b1101111) // jal
            b.pc_next = pc + j_off;
        else if (w[6:0] == 7'b1100011 && w[31]) // branch with a backward offset
            b.pc_next = pc + b_off;
        else
        begin
            b.pc_next = pc + 32'd4;
            b.br_pred = 1'b0;
        end
        return b;
    endfunction

    task automatic check_bundle(input fetch_pkg::fetch_bundle_t got,
                                input fetch_pkg::fetch_bundle_t exp, input string what);
        if (got !== exp)
        begin
            bundle_errs++;
            $display("ERROR %0t: %s pc %h inst %h next %h pred %b", $time, what,
                     got.pc, got.inst, got.pc_next, got.br_pred);
            $display("      expected pc %h inst %h next %h pred %b",
                     exp.pc, exp.inst, exp.pc_next, exp.br_pred);
        end
    endtask

    task automatic check_pc(input rv32i_pkg::rv32i_word got, input rv32i_pkg::rv32i_word exp,
                            input string what);
        if (got !== exp)
        begin
            pc_errs++;
            $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_valid(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            valid_errs++;
            $display("ERROR %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // ------------------------------------------------------------------------
    // waits that sample on the falling edge
    // ------------------------------------------------------------------------

    task automatic wait_valid();
        int n;
        n = 0;
        while (!bundle_valid && n < TIMEOUT)
        begin
            @(negedge clk);
            n++;
        end
        if (!bundle_valid)
        begin
            $display("timeout: no fetch bundle arrived within %0d cycles, waiting for pc %h",
                     TIMEOUT, model_pc);
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_setup();
        int n;
        n = 0;
        while (!(fetch_top_inst.apb_req.psel && !fetch_top_inst.apb_req.penable) &&
               n < TIMEOUT)
        begin
            @(negedge clk);
            n++;
        end
        if (!fetch_top_inst.apb_req.psel || fetch_top_inst.apb_req.penable)
        begin
            $display("timeout: no APB setup cycle seen within %0d cycles", TIMEOUT);
            timed_out = 1'b1;
        end
    endtask

    task automatic send_redirect(input rv32i_pkg::rv32i_word target);
        redirect.valid = 1'b1;
        redirect.pc = target;
        @(negedge clk);
        redirect = '0;
        model_pc = target;
        check_pc(fetch_top_inst.pc, target, "pc after redirect");
    endtask

    task automatic take_bundle(input int delay);
        fetch_pkg::fetch_bundle_t exp;
        exp = expect_bundle(model_pc);
        wait_valid();
        if (timed_out)
            return;
        check_bundle(bundle, exp, "new bundle");
        repeat (delay)
        begin
            @(negedge clk);
            check_valid(bundle_valid, 1'b1, "valid under back-pressure");
            check_bundle(bundle, exp, "held bundle");
        end
        bundle_ready = 1'b1;
        @(negedge clk);
        bundle_ready = 1'b0;
        model_pc = exp.pc_next;
        check_valid(bundle_valid, 1'b0, "valid after hand-off");
        check_pc(fetch_top_inst.pc, exp.pc_next, "pc after hand-off");
    endtask

    task automatic run_step(input step_t s);
        int delay;
        int i;
        if (s.action == ACT_IDLE)
            send_redirect(s.target);
        else if (s.action == ACT_XFER)
        begin
            wait_setup();
            if (timed_out)
                return;
            repeat (s.skew)
                @(negedge clk);
            send_redirect(s.target);
        end
        for (i = 0; i < s.count && !timed_out; i++)
        begin
            delay = s.delay;
            if (s.rand_delay)
            begin
                rng = xorshift32(rng);
                delay = rng % 5;
            end
            take_bundle(delay);
        end
    endtask

    initial
    begin
        int k;
        int sva_errs;
        clk = 1'b0;
        rst = 1'b1;
        redirect = '0;
        bundle_ready = 1'b0;
        rng = 32'h82085a5c;
        bundle_errs = 0;
        pc_errs = 0;
        valid_errs = 0;
        timed_out = 1'b0;
        $readmemh("imem.hex", mem);
        model_pc = fetch_pkg::RESET_PC;
        repeat (3)
            @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_pc(fetch_top_inst.pc, fetch_pkg::RESET_PC, "pc after reset");
        check_valid(bundle_valid, 1'b0, "valid after reset");
        for (k = 0; k < NUM_STEPS && !timed_out; k++)
            run_step(STEPS[k]);
        sva_errs = fetch_top_inst.ctrl_inst.fetch_sva_inst.fail_count;
        $display("errors: %0d bundle, %0d pc, %0d valid, %0d assertion, timeout %0d",
                 bundle_errs, pc_errs, valid_errs, sva_errs, timed_out);
        if (!timed_out && bundle_errs + pc_errs + valid_errs + sva_errs == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: imem.hex
// one 32-bit instruction word per line, word index 0 at byte address 0x00
0100006f // 0x00 jal x0, +16
00100293 // 0x04 addi x5, x0, 1
fe628ce3 // 0x08 beq x5, x6, -8
00d00693 // 0x0c addi x13, x0, 13
0ff2c393 // 0x10 xori x7, x5, 0xff
00008067 // 0x14 jalr x0, 0(x1)
0062d663 // 0x18 bge x5, x6, +12
0062e433 // 0x1c or x8, x5, x6
0062f4b3 // 0x20 and x9, x5, x6
01c0006f // 0x24 jal x0, +28
00e00713 // 0x28 addi x14, x0, 14
00f00793 // 0x2c addi x15, x0, 15
fc0008e3 // 0x30 beq x0, x0, -48
00001837 // 0x34 lui x16, 0x1
0140006f // 0x38 jal x0, +20
fff00893 // 0x3c addi x17, x0, -1
00229513 // 0x40 slli x10, x5, 2
abcde5b7 // 0x44 lui x11, 0xabcde
fe62e8e3 // 0x48 bltu x5, x6, -16
00001617 // 0x4c auipc x12, 0x1
0100006f // 0x50 jal x0, +16
004100e7 // 0x54 jalr x1, 4(x2)
fe209ce3 // 0x58 bne x1, x2, -8
0220c063 // 0x5c blt x1, x2, +32
00500093 // 0x60 addi x1, x0, 5
00300113 // 0x64 addi x2, x0, 3
002081b3 // 0x68 add x3, x1, x2
00209463 // 0x6c bne x1, x2, +8
40208233 // 0x70 sub x4, x1, x2
f91ff0ef // 0x74 jal x1, -112
7ff00913 // 0x78 addi x18, x0, 2047
00000013 // 0x7c nop

// File: flist.f
verilog/rv32i_pkg.sv
verilog/fetch_pkg.sv
verilog/inst_predecode.sv
verilog/fetch_pc.sv
verilog/imem_apb.sv
verilog/fetch_ctrl.sv
verilog/fetch_top.sv
tb/fetch_sva.sv
tb/fetch_tb.sv
